// File: source/rv_core_macros.svh
// RV64I core parameters
`ifndef RV_CORE_MACROS_SVH
`define RV_CORE_MACROS_SVH

// Integer register width
`define RV_XLEN 64

// Architectural register count
`define RV_NUM_REGS 32

// Data memory depth in doublewords, 512 bytes in all
`define RV_DMEM_WORDS 64

// First fetch address after reset
`define RV_RESET_PC 0

`endif

// File: source/rv_core_pkg.sv
// RV64I core types
`default_nettype none

`include "rv_core_macros.svh"

package rv_core_pkg;

  typedef logic [`RV_XLEN-1:0] xlen_t;
  typedef logic [31:0] inst_t;
  typedef logic [$clog2(`RV_NUM_REGS)-1:0] reg_addr_t;

  // Encoding matches the fetch resolution table
  typedef enum logic [2:0] {
    BR_NONE = 3'b000,
    BR_JAL  = 3'b001,
    BR_JALR = 3'b010,
    BR_EQ   = 3'b100,
    BR_NE   = 3'b101,
    BR_LT   = 3'b110,
    BR_GE   = 3'b111
  } branch_e;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLT,
    ALU_SLTU,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA,
    ALU_PASS_B
  } alu_op_e;

  typedef enum logic {
    A_RS1,
    A_PC
  } alu_a_sel_e;

  typedef enum logic [1:0] {
    B_RS2,
    B_IMM,
    B_FOUR
  } alu_b_sel_e;

  // Values are the load/store funct3 field
  typedef enum logic [2:0] {
    MEM_B  = 3'b000,
    MEM_H  = 3'b001,
    MEM_W  = 3'b010,
    MEM_D  = 3'b011,
    MEM_BU = 3'b100,
    MEM_HU = 3'b101,
    MEM_WU = 3'b110
  } mem_op_e;

endpackage

`default_nettype wire

// File: source/rv_ctrl_if.sv
// Decoded control bundle
`timescale 1ns/1ps
`default_nettype none

interface rv_ctrl_if;

  rv_core_pkg::branch_e    branch;
  rv_core_pkg::alu_op_e    alu_op;
  rv_core_pkg::alu_a_sel_e alu_a_sel;
  rv_core_pkg::alu_b_sel_e alu_b_sel;
  rv_core_pkg::mem_op_e    mem_op;
  logic                    mem_wr;
  logic                    mem_to_reg;
  logic                    reg_wr;
  logic                    halt;

  modport decoder (
    output branch, alu_op, alu_a_sel, alu_b_sel,
    output mem_op, mem_wr, mem_to_reg, reg_wr, halt
  );

  modport fetch (input branch, halt);

  modport exec (input alu_op, alu_a_sel, alu_b_sel);

  modport mem (input mem_op, mem_wr, mem_to_reg);

endinterface

`default_nettype wire

// File: source/rv_fetch.sv
// Program counter and halt
`timescale 1ns/1ps
`default_nettype none

`include "rv_core_macros.svh"

module rv_fetch (
  input  wire                i_clk,
  input  wire                i_reset,
  input  rv_core_pkg::xlen_t i_rs1,
  input  rv_core_pkg::xlen_t i_imm,
  input  wire                i_less,
  input  wire                i_zero,
  rv_ctrl_if.fetch           ctrl,
  output rv_core_pkg::xlen_t o_pc,
  output logic               o_halted
);

  rv_core_pkg::xlen_t pc_q;
  rv_core_pkg::xlen_t next_pc;
  logic               take_imm; // Offset is the immediate rather than four
  logic               base_rs1; // Base is rs1 rather than the PC

  always_comb begin
    take_imm = 1'b0;
    base_rs1 = 1'b0;
    case (ctrl.branch)
      rv_core_pkg::BR_JAL:  take_imm = 1'b1;
      rv_core_pkg::BR_JALR: begin
        take_imm = 1'b1;
        base_rs1 = 1'b1;
      end
      rv_core_pkg::BR_EQ:   take_imm = i_zero;
      rv_core_pkg::BR_NE:   take_imm = ~i_zero;
      rv_core_pkg::BR_LT:   take_imm = i_less;
      rv_core_pkg::BR_GE:   take_imm = ~i_less;
      default:              take_imm = 1'b0;
    endcase
  end

  assign next_pc = (base_rs1 ? i_rs1 : pc_q) + (take_imm ? i_imm : rv_core_pkg::xlen_t'(4));

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      pc_q     <= rv_core_pkg::xlen_t'(`RV_RESET_PC);
      o_halted <= 1'b0;
    end else begin
      if (ctrl.halt) o_halted <= 1'b1;
      // EBREAK holds its own PC so nothing after it retires
      if (!ctrl.halt && !o_halted) pc_q <= {next_pc[`RV_XLEN-1:1], next_pc[0] & ~base_rs1};
    end
  end

  assign o_pc = pc_q;

endmodule

`default_nettype wire

// File: source/rv_decode.sv
// RV64I instruction decoder
`timescale 1ns/1ps
`default_nettype none

module rv_decode (
  input  rv_core_pkg::inst_t     i_inst,
  output rv_core_pkg::xlen_t     o_imm,
  output rv_core_pkg::reg_addr_t o_rs1_addr,
  output rv_core_pkg::reg_addr_t o_rs2_addr,
  output rv_core_pkg::reg_addr_t o_rd_addr,
  rv_ctrl_if.decoder             ctrl
);

  localparam logic [6:0] OP_LUI    = 7'b0110111;
  localparam logic [6:0] OP_AUIPC  = 7'b0010111;
  localparam logic [6:0] OP_JAL    = 7'b1101111;
  localparam logic [6:0] OP_JALR   = 7'b1100111;
  localparam logic [6:0] OP_BRANCH = 7'b1100011;
  localparam logic [6:0] OP_LOAD   = 7'b0000011;
  localparam logic [6:0] OP_STORE  = 7'b0100011;
  localparam logic [6:0] OP_IMM    = 7'b0010011;
  localparam logic [6:0] OP_REG    = 7'b0110011;
  localparam logic [6:0] OP_SYSTEM = 7'b1110011;

  localparam rv_core_pkg::inst_t EBREAK = 32'h0010_0073;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  rv_core_pkg::xlen_t imm_i, imm_s, imm_b, imm_u, imm_j;
  rv_core_pkg::alu_op_e arith_op;

  assign opcode = i_inst[6:0];
  assign funct3 = i_inst[14:12];
  assign funct7 = i_inst[31:25];

  assign o_rd_addr  = i_inst[11:7];
  assign o_rs1_addr = i_inst[19:15];
  assign o_rs2_addr = i_inst[24:20];

  assign imm_i = {{52{i_inst[31]}}, i_inst[31:20]};
  assign imm_s = {{52{i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
  assign imm_b = {{52{i_inst[31]}}, i_inst[7], i_inst[30:25], i_inst[11:8], 1'b0};
  assign imm_u = {{32{i_inst[31]}}, i_inst[31:12], 12'b0};
  assign imm_j = {{44{i_inst[31]}}, i_inst[19:12], i_inst[20], i_inst[30:21], 1'b0};

  always_comb begin
    case (opcode)
      OP_LUI, OP_AUIPC: o_imm = imm_u;
      OP_JAL:           o_imm = imm_j;
      OP_BRANCH:        o_imm = imm_b;
      OP_STORE:         o_imm = imm_s;
      default:          o_imm = imm_i;
    endcase
  end

  // Shared by the register and immediate arithmetic forms
  always_comb begin
    case (funct3)
      3'b000:  arith_op = (opcode == OP_REG && funct7[5]) ? rv_core_pkg::ALU_SUB
                                                          : rv_core_pkg::ALU_ADD;
      3'b001:  arith_op = rv_core_pkg::ALU_SLL;
      3'b010:  arith_op = rv_core_pkg::ALU_SLT;
      3'b011:  arith_op = rv_core_pkg::ALU_SLTU;
      3'b100:  arith_op = rv_core_pkg::ALU_XOR;
      3'b101:  arith_op = funct7[5] ? rv_core_pkg::ALU_SRA : rv_core_pkg::ALU_SRL;
      3'b110:  arith_op = rv_core_pkg::ALU_OR;
      default: arith_op = rv_core_pkg::ALU_AND;
    endcase
  end

  always_comb begin
    ctrl.branch     = rv_core_pkg::BR_NONE;
    ctrl.alu_op     = rv_core_pkg::ALU_ADD;
    ctrl.alu_a_sel  = rv_core_pkg::A_RS1;
    ctrl.alu_b_sel  = rv_core_pkg::B_RS2;
    ctrl.mem_op     = rv_core_pkg::mem_op_e'(funct3);
    ctrl.mem_wr     = 1'b0;
    ctrl.mem_to_reg = 1'b0;
    ctrl.reg_wr     = 1'b0;
    ctrl.halt       = 1'b0;
    case (opcode)
      OP_LUI: begin
        ctrl.alu_op    = rv_core_pkg::ALU_PASS_B;
        ctrl.alu_b_sel = rv_core_pkg::B_IMM;
        ctrl.reg_wr    = 1'b1;
      end
      OP_AUIPC: begin
        ctrl.alu_a_sel = rv_core_pkg::A_PC;
        ctrl.alu_b_sel = rv_core_pkg::B_IMM;
        ctrl.reg_wr    = 1'b1;
      end
      OP_JAL, OP_JALR: begin
        ctrl.branch    = (opcode == OP_JAL) ? rv_core_pkg::BR_JAL : rv_core_pkg::BR_JALR;
        ctrl.alu_a_sel = rv_core_pkg::A_PC; // Link value is PC plus four
        ctrl.alu_b_sel = rv_core_pkg::B_FOUR;
        ctrl.reg_wr    = 1'b1;
      end
      OP_BRANCH: begin
        case (funct3)
          3'b000:  ctrl.branch = rv_core_pkg::BR_EQ;
          3'b001:  ctrl.branch = rv_core_pkg::BR_NE;
          3'b100,
          3'b110:  ctrl.branch = rv_core_pkg::BR_LT;
          3'b101,
          3'b111:  ctrl.branch = rv_core_pkg::BR_GE;
          default: ctrl.branch = rv_core_pkg::BR_NONE;
        endcase
        if (!funct3[2]) ctrl.alu_op = rv_core_pkg::ALU_SUB;
        else if (funct3[1]) ctrl.alu_op = rv_core_pkg::ALU_SLTU;
        else ctrl.alu_op = rv_core_pkg::ALU_SLT;
      end
      OP_LOAD: begin
        ctrl.alu_b_sel  = rv_core_pkg::B_IMM;
        ctrl.mem_to_reg = 1'b1;
        ctrl.reg_wr     = 1'b1;
      end
      OP_STORE: begin
        ctrl.alu_b_sel = rv_core_pkg::B_IMM;
        ctrl.mem_wr    = 1'b1;
      end
      OP_IMM: begin
        ctrl.alu_op    = arith_op;
        ctrl.alu_b_sel = rv_core_pkg::B_IMM;
        ctrl.reg_wr    = 1'b1;
      end
      OP_REG: begin
        ctrl.alu_op = arith_op;
        ctrl.reg_wr = 1'b1;
      end
      OP_SYSTEM: ctrl.halt = (i_inst == EBREAK);
      default: ;
    endcase
  end

endmodule

`default_nettype wire

// File: source/rv_regfile.sv
// General-purpose registers
`timescale 1ns/1ps
`default_nettype none

`include "rv_core_macros.svh"

module rv_regfile (
  input  wire                    i_clk,
  input  rv_core_pkg::reg_addr_t i_rs1_addr,
  input  rv_core_pkg::reg_addr_t i_rs2_addr,
  input  rv_core_pkg::reg_addr_t i_rd_addr,
  input  rv_core_pkg::xlen_t     i_wdata,
  input  wire                    i_wen,
  output rv_core_pkg::xlen_t     o_rs1,
  output rv_core_pkg::xlen_t     o_rs2
);

  rv_core_pkg::xlen_t regs [`RV_NUM_REGS];

  always_ff @(posedge i_clk) begin
    if (i_wen && i_rd_addr != '0) regs[i_rd_addr] <= i_wdata;
  end

  // x0 is never written, so its entry is bypassed on read
  assign o_rs1 = (i_rs1_addr == '0) ? '0 : regs[i_rs1_addr];
  assign o_rs2 = (i_rs2_addr == '0) ? '0 : regs[i_rs2_addr];

endmodule

`default_nettype wire

// File: source/rv_alu.sv
// Execute ALU with branch flags
`timescale 1ns/1ps
`default_nettype none

module rv_alu (
  input  rv_core_pkg::xlen_t i_rs1,
  input  rv_core_pkg::xlen_t i_rs2,
  input  rv_core_pkg::xlen_t i_imm,
  input  rv_core_pkg::xlen_t i_pc,
  rv_ctrl_if.exec            ctrl,
  output rv_core_pkg::xlen_t o_result,
  output logic               o_less,
  output logic               o_zero
);

  rv_core_pkg::xlen_t op_a;
  rv_core_pkg::xlen_t op_b;
  logic [5:0]         shamt;

  assign op_a = (ctrl.alu_a_sel == rv_core_pkg::A_PC) ? i_pc : i_rs1;

  always_comb begin
    case (ctrl.alu_b_sel)
      rv_core_pkg::B_IMM:  op_b = i_imm;
      rv_core_pkg::B_FOUR: op_b = rv_core_pkg::xlen_t'(4);
      default:             op_b = i_rs2;
    endcase
  end

  assign shamt = op_b[5:0]; // RV64 shifts use six bits

  always_comb begin
    case (ctrl.alu_op)
      rv_core_pkg::ALU_SUB:    o_result = op_a - op_b;
      rv_core_pkg::ALU_SLT:    o_result = rv_core_pkg::xlen_t'($signed(op_a) < $signed(op_b));
      rv_core_pkg::ALU_SLTU:   o_result = rv_core_pkg::xlen_t'(op_a < op_b);
      rv_core_pkg::ALU_AND:    o_result = op_a & op_b;
      rv_core_pkg::ALU_OR:     o_result = op_a | op_b;
      rv_core_pkg::ALU_XOR:    o_result = op_a ^ op_b;
      rv_core_pkg::ALU_SLL:    o_result = op_a << shamt;
      rv_core_pkg::ALU_SRL:    o_result = op_a >> shamt;
      rv_core_pkg::ALU_SRA:    o_result = rv_core_pkg::xlen_t'($signed(op_a) >>> shamt);
      rv_core_pkg::ALU_PASS_B: o_result = op_b;
      default:                 o_result = op_a + op_b;
    endcase
  end

  // Less only means something when the op is slt or sltu
  assign o_less = o_result[0];
  assign o_zero = (o_result == '0);

endmodule

`default_nettype wire

// File: source/rv_lsu.sv
// Load/store unit and writeback select
`timescale 1ns/1ps
`default_nettype none

`include "rv_core_macros.svh"

module rv_lsu (
  input  wire                i_clk,
  input  rv_core_pkg::xlen_t i_addr,
  input  rv_core_pkg::xlen_t i_store_data,
  input  rv_core_pkg::xlen_t i_alu_result,
  rv_ctrl_if.mem             ctrl,
  output rv_core_pkg::xlen_t o_wb_data
);

  localparam int IDX_W = $clog2(`RV_DMEM_WORDS);

  rv_core_pkg::xlen_t mem [`RV_DMEM_WORDS];

  logic [IDX_W-1:0]   index;
  logic [2:0]         offset;
  logic [7:0]         lane_mask;
  rv_core_pkg::xlen_t wr_data;
  rv_core_pkg::xlen_t rd_shifted;
  rv_core_pkg::xlen_t load_data;

  assign index  = i_addr[IDX_W+2:3];
  assign offset = i_addr[2:0];

  // Size in the low two bits of the op, placed at the byte offset
  always_comb begin
    case (ctrl.mem_op[1:0])
      2'b00:   lane_mask = 8'h01 << offset;
      2'b01:   lane_mask = 8'h03 << offset;
      2'b10:   lane_mask = 8'h0f << offset;
      default: lane_mask = 8'hff;
    endcase
  end

  assign wr_data = i_store_data << {offset, 3'b000};

  always_ff @(posedge i_clk) begin
    if (ctrl.mem_wr) begin
      for (int i = 0; i < 8; i++) begin
        if (lane_mask[i]) mem[index][i*8 +: 8] <= wr_data[i*8 +: 8];
      end
    end
  end

  assign rd_shifted = mem[index] >> {offset, 3'b000};

  always_comb begin
    case (ctrl.mem_op)
      rv_core_pkg::MEM_B:  load_data = {{(`RV_XLEN-8){rd_shifted[7]}}, rd_shifted[7:0]};
      rv_core_pkg::MEM_H:  load_data = {{(`RV_XLEN-16){rd_shifted[15]}}, rd_shifted[15:0]};
      rv_core_pkg::MEM_W:  load_data = {{(`RV_XLEN-32){rd_shifted[31]}}, rd_shifted[31:0]};
      rv_core_pkg::MEM_BU: load_data = {{(`RV_XLEN-8){1'b0}}, rd_shifted[7:0]};
      rv_core_pkg::MEM_HU: load_data = {{(`RV_XLEN-16){1'b0}}, rd_shifted[15:0]};
      rv_core_pkg::MEM_WU: load_data = {{(`RV_XLEN-32){1'b0}}, rd_shifted[31:0]};
      default:             load_data = rd_shifted;
    endcase
  end

  assign o_wb_data = ctrl.mem_to_reg ? load_data : i_alu_result;

endmodule

`default_nettype wire

// File: source/rv_core.sv
// Single-cycle RV64I core
`timescale 1ns/1ps
`default_nettype none

module rv_core (
  input  wire                    i_clk,
  input  wire                    i_reset,
  input  rv_core_pkg::inst_t     i_inst,
  output rv_core_pkg::xlen_t     o_pc,
  output logic                   o_wb_en,
  output rv_core_pkg::reg_addr_t o_wb_rd,
  output rv_core_pkg::xlen_t     o_wb_data,
  output logic                   o_halted
);

  rv_core_pkg::xlen_t     imm, rs1, rs2, alu_result, wb_data;
  rv_core_pkg::reg_addr_t rs1_addr, rs2_addr, rd_addr;
  logic                   less, zero;

  rv_ctrl_if u_ctrl ();

  rv_fetch u_fetch (
    .i_clk(i_clk), .i_reset(i_reset),
    .i_rs1(rs1), .i_imm(imm),
    .i_less(less), .i_zero(zero),
    .ctrl(u_ctrl.fetch),
    .o_pc(o_pc), .o_halted(o_halted)
  );

  rv_decode u_decode (
    .i_inst(i_inst), .o_imm(imm),
    .o_rs1_addr(rs1_addr), .o_rs2_addr(rs2_addr), .o_rd_addr(rd_addr),
    .ctrl(u_ctrl.decoder)
  );

  // Nothing retires during reset or once halted
  assign o_wb_en   = u_ctrl.reg_wr & ~i_reset & ~o_halted;
  assign o_wb_rd   = rd_addr;
  assign o_wb_data = wb_data;

  rv_regfile u_regfile (
    .i_clk(i_clk),
    .i_rs1_addr(rs1_addr), .i_rs2_addr(rs2_addr), .i_rd_addr(rd_addr),
    .i_wdata(wb_data), .i_wen(o_wb_en),
    .o_rs1(rs1), .o_rs2(rs2)
  );

  rv_alu u_alu (
    .i_rs1(rs1), .i_rs2(rs2), .i_imm(imm), .i_pc(o_pc),
    .ctrl(u_ctrl.exec),
    .o_result(alu_result), .o_less(less), .o_zero(zero)
  );

  rv_lsu u_lsu (
    .i_clk(i_clk),
    .i_addr(alu_result), .i_store_data(rs2), .i_alu_result(alu_result),
    .ctrl(u_ctrl.mem),
    .o_wb_data(wb_data)
  );

endmodule

`default_nettype wire

// File: tests/rv_core_tb.sv
// RV64I core testbench
`timescale 1ns/1ps
`default_nettype none

module rv_core_tb;

  localparam int          PROG_WORDS  = 256;
  localparam int          MAX_ENTRIES = 128;
  localparam logic [31:0] NOP         = 32'h0000_0013; // addi x0, x0, 0

  logic                   i_clk;
  logic                   i_reset;
  rv_core_pkg::inst_t     i_inst;
  rv_core_pkg::xlen_t     o_pc;
  logic                   o_wb_en;
  rv_core_pkg::reg_addr_t o_wb_rd;
  rv_core_pkg::xlen_t     o_wb_data;
  logic                   o_halted;

  logic [31:0] prog [PROG_WORDS];
  int          exp_test [MAX_ENTRIES];
  logic [4:0]  exp_rd [MAX_ENTRIES];
  logic [63:0] exp_data [MAX_ENTRIES];
  int          n_prog;
  int          n_exp;
  int          exp_idx;
  int          halt_test;
  logic [63:0] halt_pc;
  int          errors;
  int          test_errors;
  int          tests_run;
  bit          loaded;

  rv_core i_dut (
    .i_clk(i_clk), .i_reset(i_reset), .i_inst(i_inst), .o_pc(o_pc),
    .o_wb_en(o_wb_en), .o_wb_rd(o_wb_rd), .o_wb_data(o_wb_data), .o_halted(o_halted)
  );

  always #10 i_clk = ~i_clk;

  // Records are P (program word), E (expected writeback) and H (halt PC)
  task automatic load_stimulus();
    int               fd;
    int               code;
    bit               bad;
    byte              tag;
    logic [63:0]      addr;
    logic [31:0]      word;
    int               tnum;
    logic [4:0]       rd;
    logic [63:0]      value;
    logic [8*128-1:0] rest;
    fd = $fopen("tests/rv_core_stim.txt", "r");
    if (fd == 0) begin
      $display("Cannot open tests/rv_core_stim.txt, the core will run without a program");
      errors++;
    end else begin
      while ($fscanf(fd, " %c", tag) == 1) begin
        bad = 1'b0;
        case (tag)
          "P": begin
            code = $fscanf(fd, "%h %h", addr, word);
            if (code != 2 || addr >= PROG_WORDS) begin
              bad = 1'b1;
            end else begin
              prog[addr] = word;
              n_prog++;
            end
          end
          "E": begin
            code = $fscanf(fd, "%d %d %h", tnum, rd, value);
            if (code != 3 || n_exp >= MAX_ENTRIES) begin
              bad = 1'b1;
            end else begin
              exp_test[n_exp] = tnum;
              exp_rd[n_exp]   = rd;
              exp_data[n_exp] = value;
              n_exp++;
            end
          end
          "H": begin
            code = $fscanf(fd, "%d %h", halt_test, halt_pc);
            bad  = (code != 2);
          end
          "#": code = $fgets(rest, fd); // Rest of the line is a note
          default: bad = 1'b1;
        endcase
        if (bad) begin
          $display("Stimulus file has a malformed or unknown record of type %c", tag);
          errors++;
        end
      end
      $fclose(fd);
    end
  endtask

  function automatic logic [31:0] inst_at(rv_core_pkg::xlen_t pc);
    if ($isunknown(pc) || (pc >> 2) >= PROG_WORDS) return NOP;
    return prog[pc >> 2];
  endfunction

  // Compare one retiring write with the next trace entry
  task automatic check_writeback();
    if (exp_idx >= n_exp) begin
      $display("Unexpected writeback of %h to x%0d at %0t after the trace ended",
               o_wb_data, o_wb_rd, $time);
      errors++;
      return;
    end
    if (o_wb_rd !== exp_rd[exp_idx]) begin
      $display("Error at %0t: o_wb_rd is %0d, expected %0d", $time, o_wb_rd, exp_rd[exp_idx]);
      errors++;
      test_errors++;
    end
    if (o_wb_data !== exp_data[exp_idx]) begin
      $display("Error at %0t: o_wb_data is %h, expected %h", $time, o_wb_data,
               exp_data[exp_idx]);
      errors++;
      test_errors++;
    end
    if (exp_idx + 1 == n_exp || exp_test[exp_idx + 1] != exp_test[exp_idx]) begin
      $display("Test %0d done, %0d errors", exp_test[exp_idx], test_errors);
      test_errors = 0;
      tests_run++;
    end
    exp_idx++;
  endtask

  always @(negedge i_clk) i_inst = inst_at(o_pc); // PC settles after the rising edge

  always @(posedge i_clk) begin
    if (i_reset) begin
      if (o_wb_en !== 1'b0) begin
        $display("Error at %0t: o_wb_en is %b during reset, expected 0", $time, o_wb_en);
        errors++;
      end
    end else if (o_wb_en === 1'b1 && o_wb_rd != '0) begin
      check_writeback();
    end
  end

  initial begin
    i_clk       = 1'b0;
    i_reset     = 1'b1;
    i_inst      = NOP;
    n_prog      = 0;
    n_exp       = 0;
    exp_idx     = 0;
    halt_test   = 0;
    halt_pc     = '0;
    errors      = 0;
    test_errors = 0;
    tests_run   = 0;
    for (int i = 0; i < PROG_WORDS; i++) prog[i] = NOP;
    load_stimulus();
    loaded = 1'b1;
    repeat (4) @(negedge i_clk);
    i_reset = 1'b0;
    if (o_pc !== 64'h0) begin
      $display("Error at %0t: o_pc is %h after reset, expected %h", $time, o_pc, 64'h0);
      errors++;
    end
    if (o_halted !== 1'b0) begin
      $display("Error at %0t: o_halted is %b after reset, expected 0", $time, o_halted);
      errors++;
    end
    wait (o_halted === 1'b1);
    // A few more edges so that a write after EBREAK would be caught
    repeat (3) @(posedge i_clk);
    @(negedge i_clk);
    test_errors = 0;
    if (o_pc !== halt_pc) begin
      $display("Error at %0t: o_pc is %h, expected %h", $time, o_pc, halt_pc);
      errors++;
      test_errors++;
    end
    if (exp_idx != n_exp) begin
      $display("The core halted with %0d expected writebacks never seen", n_exp - exp_idx);
      errors++;
      test_errors++;
    end
    tests_run++;
    $display("Test %0d done, %0d errors", halt_test, test_errors);
    $display("Tests run: %0d, writebacks checked: %0d, errors: %0d", tests_run, exp_idx, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

  // One cycle per program word and fifty more for reset and the halt
  initial begin
    wait (loaded);
    #(20 * (n_prog + 50));
    $display("Timeout: o_halted did not rise within %0d cycles", n_prog + 50);
    $display("Done: errors found");
    $finish;
  end

endmodule

`default_nettype wire

// File: tests/rv_core_stim.txt
# P word_addr(hex) instruction(hex) | E test rd(dec) value(hex) | H test halt_pc(hex)
# An E record follows the instruction that retires it, text after # is a note
P 00 00500093  E 1 1 0000000000000005  # addi x1, x0, 5
P 01 FFF00113  E 1 2 FFFFFFFFFFFFFFFF  # addi x2, x0, -1
P 02 002081B3  E 1 3 0000000000000004  # add x3, x1, x2
P 03 40208233  E 1 4 0000000000000006  # sub x4, x1, x2
P 04 001122B3  E 1 5 0000000000000001  # slt x5, x2, x1
P 05 00113333  E 1 6 0000000000000000  # sltu x6, x2, x1
P 06 0020C3B3  E 1 7 FFFFFFFFFFFFFFFA  # xor x7, x1, x2
P 07 0F00E413  E 1 8 00000000000000F5  # ori x8, x1, 0xf0
P 08 002474B3  E 1 9 00000000000000F5  # and x9, x8, x2
P 09 03F09513  E 1 10 8000000000000000  # slli x10, x1, 63
P 0A 43C55593  E 1 11 FFFFFFFFFFFFFFF8  # srai x11, x10, 60
P 0B 00155633  E 1 12 0400000000000000  # srl x12, x10, x1
P 0C 00708013  # addi x0, x1, 7 leaves x0 at zero
P 0D 00100733  E 1 14 0000000000000005  # add x14, x0, x1
P 0E 800007B7  E 2 15 FFFFFFFF80000000  # lui x15, 0x80000
P 0F 12345817  E 2 16 000000001234503C  # auipc x16, 0x12345 at pc 0x3c
P 10 00F848B3  E 3 17 FFFFFFFF9234503C  # xor x17, x16, x15
P 11 05103023  P 12 041000A3  P 13 04802223  P 14 04B01323  # sd 0x40, sb 0x41, sw 0x44, sh 0x46
P 15 04003903  E 3 18 FFF800F59234053C  # ld x18, 0x40(x0)
P 16 04300983  E 3 19 FFFFFFFFFFFFFF92  # lb x19, 0x43(x0)
P 17 04304A03  E 3 20 0000000000000092  # lbu x20, 0x43(x0)
P 18 04601A83  E 3 21 FFFFFFFFFFFFFFF8  # lh x21, 0x46(x0)
P 19 04205B03  E 3 22 0000000000009234  # lhu x22, 0x42(x0)
P 1A 04002B83  E 3 23 FFFFFFFF9234053C  # lw x23, 0x40(x0)
P 1B 04406C03  E 3 24 00000000FFF800F5  # lwu x24, 0x44(x0)
P 1C 00208463  P 1D 00E08463  P 1E 00100F93  # beq not taken, beq taken, marker
P 1F 00E09463  P 20 00209463  P 21 00200F93  # bne not taken, bne taken, marker
P 22 0020C463  P 23 00114463  P 24 00300F93  # blt not taken, blt taken, marker
P 25 00115463  P 26 0020D463  P 27 00400F93  # bge not taken, bge taken, marker
P 28 00116463  P 29 0020E463  P 2A 00500F93  # bltu not taken, bltu taken, marker
P 2B 0020F463  P 2C 00117463  P 2D 00600F93  # bgeu not taken, bgeu taken, marker
P 2E 00600C93  E 4 25 0000000000000006  # addi x25, x0, 6
P 2F 00800D6F  E 5 26 00000000000000C0  P 30 00700F93  # jal x26, +8 over a marker
P 31 0CC00D93  E 5 27 00000000000000CC  # addi x27, x0, 0xcc
P 32 005D8E67  E 5 28 00000000000000CC  P 33 00800F93  # jalr x28, 5(x27) to 0xd0
P 34 00100073  H 6 00000000000000D0  P 35 00900F93  # ebreak, then a marker

// File: sim.f
+incdir+source
source/rv_core_pkg.sv
source/rv_ctrl_if.sv
source/rv_fetch.sv
source/rv_decode.sv
source/rv_regfile.sv
source/rv_alu.sv
source/rv_lsu.sv
source/rv_core.sv
tests/rv_core_tb.sv

// File: Bender.yml
package:
  name: rv_core

sources:
  - include_dirs:
      - source
    files:
      - source/rv_core_pkg.sv
      - source/rv_ctrl_if.sv
      - source/rv_fetch.sv
      - source/rv_decode.sv
      - source/rv_regfile.sv
      - source/rv_alu.sv
      - source/rv_lsu.sv
      - source/rv_core.sv
  - target: test
    files:
      - tests/rv_core_tb.sv
